/* hdl/lsp_defines.svh */
//--------------------------------------------------------------------
// sizes are compile-time only and every per-CQ and per-slot vector follows them
// the CQ count and slots per CQ are expected to be powers of two
//--------------------------------------------------------------------
`ifndef LSP_DEFINES_SVH
`define LSP_DEFINES_SVH

// number of load-balanced consumer queues
`define LSP_NUM_LB_CQ 8
// qidix slots owned by each CQ
`define LSP_QID_PER_CQ 4
// entries a CQ can hold before it reports no space
`define LSP_CQ_DEPTH 4

// derived widths, one flat bit per slot across all CQs
`define LSP_NUM_CQ_QID (`LSP_NUM_LB_CQ * `LSP_QID_PER_CQ)
`define LSP_CQ_W $clog2(`LSP_NUM_LB_CQ)
`define LSP_QIDIX_W $clog2(`LSP_QID_PER_CQ)
`define LSP_CNT_W $clog2(`LSP_CQ_DEPTH + 1)

`endif

/* hdl/lsp_cfg_pkg.sv */
//--------------------------------------------------------------------
// configuration fields are static levels with no register interface
//--------------------------------------------------------------------
`include "lsp_defines.svh"

package lsp_cfg_pkg;

  //--------------------------------------------------------------------
  // slist blast handling
  //--------------------------------------------------------------------

  // in slot mode only the qidix whose blast bit is set is held back
  // in CQ mode any slist blast bit in a CQ holds back every slist slot of
  // that CQ, so a lower priority atomic qid cannot overtake a blasted one
  typedef enum logic {
    SLIST_BLAST_SLOT = 1'b0,
    SLIST_BLAST_CQ   = 1'b1
  } slist_mode_e;

  //--------------------------------------------------------------------
  // control word
  //--------------------------------------------------------------------

  // one mode bit followed by the per-CQ load-balance disable vector
  // a disabled CQ still reports its work but never raises a request
  typedef struct packed {
    slist_mode_e               slist_mode;
    logic [`LSP_NUM_LB_CQ-1:0] cq_ldb_disable;
  } lsp_cfg_t;

  // bit 8 holds the mode and bits 7:0 the disables
  // the struct is meant to be driven as one 9-bit level

endpackage

/* hdl/lsp_sched_pkg.sv */
//--------------------------------------------------------------------
// schedule types shared by the selector, slot picker and credit block
//--------------------------------------------------------------------
`include "lsp_defines.svh"

package lsp_sched_pkg;

  //--------------------------------------------------------------------
  // list encoding
  //--------------------------------------------------------------------

  // the encoding also reflects pick priority inside a CQ
  // slist goes first, then the replay list, then non-atomic work
  typedef enum logic [1:0] {
    LIST_SLIST = 2'd0,
    LIST_RLIST = 2'd1,
    LIST_NALB  = 2'd2
  } list_e;

  //--------------------------------------------------------------------
  // per-slot vectors
  //--------------------------------------------------------------------

  // one bit per qidix slot of every CQ, CQ n owns bits n*QID_PER_CQ and up
  // the same layout carries raw valid bits, blast bits and the qualified
  // vectors that the selector hands to the slot picker
  typedef struct packed {
    logic [`LSP_NUM_CQ_QID-1:0] slist;
    logic [`LSP_NUM_CQ_QID-1:0] rlist;
    logic [`LSP_NUM_CQ_QID-1:0] nalb;
  } slot_vec_t;

  //--------------------------------------------------------------------
  // schedule result
  //--------------------------------------------------------------------

  // only meaningful in a cycle where sched_v is high
  typedef struct packed {
    logic [`LSP_CQ_W-1:0]    cq;
    logic [`LSP_QIDIX_W-1:0] qidix;
    list_e                   list;
  } sched_t;

endpackage

/* hdl/lsp_cq_sel.sv */
//--------------------------------------------------------------------
// purely combinational, requests depend on the credit state of the same cycle
//--------------------------------------------------------------------
`include "lsp_defines.svh"

module lsp_cq_sel (
  input  lsp_cfg_pkg::lsp_cfg_t       cfg,
  input  lsp_sched_pkg::slot_vec_t    valid,
  input  lsp_sched_pkg::slot_vec_t    blast,
  input  logic [`LSP_NUM_CQ_QID-1:0]  cmpblast,
  input  logic [`LSP_NUM_CQ_QID-1:0]  atm_if_v,
  input  logic [`LSP_NUM_LB_CQ-1:0]   cq_has_space,
  input  logic [`LSP_NUM_LB_CQ-1:0]   cq_busy_sch,
  input  logic [`LSP_NUM_LB_CQ-1:0]   cq_ow,
  output lsp_sched_pkg::slot_vec_t    v_blasted,
  output logic [`LSP_NUM_LB_CQ-1:0]   any_has_work,
  output logic [`LSP_NUM_LB_CQ-1:0]   cq_arb_reqs
);

  // effective slist blast after the mode has been applied
  logic [`LSP_NUM_CQ_QID-1:0] slist_blk;
  logic [`LSP_NUM_LB_CQ-1:0]  slist_has_work;
  logic [`LSP_NUM_LB_CQ-1:0]  rlist_has_work;
  logic [`LSP_NUM_LB_CQ-1:0]  nalb_has_work;

  //--------------------------------------------------------------------
  // per-slot qualification
  //--------------------------------------------------------------------

  // in CQ mode the blast bits of a CQ are ORed and spread back over all its slots
  always_comb begin
    for (int i = 0; i < `LSP_NUM_LB_CQ; i++) begin
      if (cfg.slist_mode == lsp_cfg_pkg::SLIST_BLAST_CQ) begin
        slist_blk[i*`LSP_QID_PER_CQ +: `LSP_QID_PER_CQ] =
          {`LSP_QID_PER_CQ{|blast.slist[i*`LSP_QID_PER_CQ +: `LSP_QID_PER_CQ]}};
      end else begin
        slist_blk[i*`LSP_QID_PER_CQ +: `LSP_QID_PER_CQ] =
          blast.slist[i*`LSP_QID_PER_CQ +: `LSP_QID_PER_CQ];
      end
    end
  end

  // atomic lists need the inflight qualifier, replay also waits on completion blast
  assign v_blasted.slist = valid.slist & atm_if_v & ~slist_blk;
  assign v_blasted.rlist = valid.rlist & atm_if_v & ~blast.rlist & ~cmpblast;
  assign v_blasted.nalb  = valid.nalb & ~blast.nalb;

  //--------------------------------------------------------------------
  // per-CQ reduction and requests
  //--------------------------------------------------------------------

  // a CQ has work on a list if any of its slots survived qualification
  always_comb begin
    for (int i = 0; i < `LSP_NUM_LB_CQ; i++) begin
      slist_has_work[i] = |v_blasted.slist[i*`LSP_QID_PER_CQ +: `LSP_QID_PER_CQ];
      rlist_has_work[i] = |v_blasted.rlist[i*`LSP_QID_PER_CQ +: `LSP_QID_PER_CQ];
      nalb_has_work[i]  = |v_blasted.nalb[i*`LSP_QID_PER_CQ +: `LSP_QID_PER_CQ];
    end
  end

  assign any_has_work = slist_has_work | rlist_has_work | nalb_has_work;

  // space is shared by all lists, so a full or blocked CQ drops every request
  assign cq_arb_reqs = any_has_work & cq_has_space & ~cq_busy_sch & ~cq_ow
                       & ~cfg.cq_ldb_disable;

endmodule

/* hdl/lsp_cq_arb.sv */
//--------------------------------------------------------------------
// the winner is combinational, the caller registers it, only the pointer is state
//--------------------------------------------------------------------
`include "lsp_defines.svh"

module lsp_cq_arb (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [`LSP_NUM_LB_CQ-1:0]  reqs,
  output logic                       gnt_v,
  output logic [`LSP_CQ_W-1:0]       gnt_cq
);

  // first CQ to look at on the next search, one past the last winner
  logic [`LSP_CQ_W-1:0] rr_ptr;

  //--------------------------------------------------------------------
  // winner search
  //--------------------------------------------------------------------

  // walk the requests starting at rr_ptr and wrapping around
  // the loop runs from the farthest offset back to the nearest so that
  // the last hit, which is the one kept, is the nearest to the pointer
  always_comb begin
    int idx;
    gnt_v  = 1'b0;
    gnt_cq = '0;
    for (int i = `LSP_NUM_LB_CQ - 1; i >= 0; i--) begin
      idx = (int'(rr_ptr) + i) % `LSP_NUM_LB_CQ;
      if (reqs[idx]) begin
        gnt_v  = 1'b1;
        gnt_cq = idx[`LSP_CQ_W-1:0];
      end
    end
  end

  // with no request at all gnt_cq stays at zero and gnt_v is low
  // downstream logic looks at gnt_cq only together with gnt_v

  //--------------------------------------------------------------------
  // round-robin pointer
  //--------------------------------------------------------------------

  // after reset the search begins at CQ 0
  // the pointer only moves when something was granted, so an idle cycle
  // keeps the fairness position
  // the CQ count is a power of two, so one past the last CQ wraps to CQ 0
  always_ff @(posedge clk) begin
    if (rst) begin
      rr_ptr <= '0;
    end else if (gnt_v) begin
      rr_ptr <= gnt_cq + 1'b1;
    end
  end

  // a CQ that just won is also held off for one cycle by busy_sch in the
  // selector, so back to back grants to one CQ cannot happen even when it
  // is the only requester

endmodule

/* hdl/lsp_qidix_sel.sv */
//--------------------------------------------------------------------
// picks list then lowest qidix of the granted CQ and registers the result
//--------------------------------------------------------------------
`include "lsp_defines.svh"

module lsp_qidix_sel (
  input  logic                      clk,
  input  logic                      rst,
  input  lsp_sched_pkg::slot_vec_t  v_blasted,
  input  logic                      gnt_v,
  input  logic [`LSP_CQ_W-1:0]      gnt_cq,
  output logic                      sched_v,
  output lsp_sched_pkg::sched_t     sched
);

  logic [`LSP_QID_PER_CQ-1:0] sl_slots;
  logic [`LSP_QID_PER_CQ-1:0] rl_slots;
  logic [`LSP_QID_PER_CQ-1:0] nb_slots;
  logic [`LSP_QID_PER_CQ-1:0] pick_slots;
  lsp_sched_pkg::list_e       pick_list;
  logic [`LSP_QIDIX_W-1:0]    pick_qidix;

  // slots of the granted CQ on each list
  assign sl_slots = v_blasted.slist[gnt_cq*`LSP_QID_PER_CQ +: `LSP_QID_PER_CQ];
  assign rl_slots = v_blasted.rlist[gnt_cq*`LSP_QID_PER_CQ +: `LSP_QID_PER_CQ];
  assign nb_slots = v_blasted.nalb[gnt_cq*`LSP_QID_PER_CQ +: `LSP_QID_PER_CQ];

  // fixed list priority, the grant guarantees at least one list has work
  always_comb begin
    if (|sl_slots) begin
      pick_list  = lsp_sched_pkg::LIST_SLIST;
      pick_slots = sl_slots;
    end else if (|rl_slots) begin
      pick_list  = lsp_sched_pkg::LIST_RLIST;
      pick_slots = rl_slots;
    end else begin
      pick_list  = lsp_sched_pkg::LIST_NALB;
      pick_slots = nb_slots;
    end
  end

  // lowest set qidix wins, scanning downward so the last hit is the lowest
  always_comb begin
    pick_qidix = '0;
    for (int i = `LSP_QID_PER_CQ - 1; i >= 0; i--) begin
      if (pick_slots[i]) begin
        pick_qidix = i[`LSP_QIDIX_W-1:0];
      end
    end
  end

  // strobe comes out one cycle after the sampled requests
  always_ff @(posedge clk) begin
    if (rst) begin
      sched_v <= 1'b0;
    end else begin
      sched_v <= gnt_v;
    end
  end

  // result only loads on a grant and is read only while sched_v is high
  always_ff @(posedge clk) begin
    if (gnt_v) begin
      sched <= '{cq: gnt_cq, qidix: pick_qidix, list: pick_list};
    end
  end

endmodule

/* hdl/lsp_cq_credit.sv */
//--------------------------------------------------------------------
// occupancy saturates at the CQ depth, pops on an empty CQ are dropped
//--------------------------------------------------------------------
`include "lsp_defines.svh"

module lsp_cq_credit (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       sched_v,
  input  lsp_sched_pkg::sched_t      sched,
  input  logic                       cq_pop,
  input  logic [`LSP_CQ_W-1:0]       pop_cq,
  output logic [`LSP_NUM_LB_CQ-1:0]  cq_has_space,
  output logic [`LSP_NUM_LB_CQ-1:0]  cq_busy_sch
);

  // entries currently held by each CQ
  logic [`LSP_CNT_W-1:0]     occ [`LSP_NUM_LB_CQ];
  // qualified decrement, only for a CQ that holds something
  logic [`LSP_NUM_LB_CQ-1:0] pop_dec;

  //--------------------------------------------------------------------
  // decode of schedule and pop strobes
  //--------------------------------------------------------------------

  // busy_sch doubles as the increment, it marks the CQ of the live schedule
  always_comb begin
    for (int i = 0; i < `LSP_NUM_LB_CQ; i++) begin
      cq_busy_sch[i]  = sched_v && (sched.cq == i);
      pop_dec[i]      = cq_pop && (pop_cq == i) && (occ[i] != '0);
      cq_has_space[i] = (occ[i] < `LSP_CQ_DEPTH);
    end
  end

  //--------------------------------------------------------------------
  // occupancy counters
  //--------------------------------------------------------------------

  // a schedule and a pop on the same CQ cancel out
  // the count never exceeds the depth, the selector stops requesting first
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `LSP_NUM_LB_CQ; i++) begin
        occ[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `LSP_NUM_LB_CQ; i++) begin
        if (cq_busy_sch[i] && !pop_dec[i]) begin
          if (cq_has_space[i]) begin
            occ[i] <= occ[i] + 1'b1;
          end
        end else if (pop_dec[i] && !cq_busy_sch[i]) begin
          occ[i] <= occ[i] - 1'b1;
        end
      end
    end
  end

  // a CQ at depth-1 that gets scheduled is still blocked in the strobe cycle
  // by busy_sch, and by the following cycle its count already reads full
  // so the counter and the request mask never race each other

endmodule

/* hdl/lsp_sched_top.sv */
//--------------------------------------------------------------------
// one schedule per cycle at most, no back-pressure on the sched strobe
//--------------------------------------------------------------------
`include "lsp_defines.svh"

module lsp_sched_top (
  input  logic                       clk,
  input  logic                       rst,
  input  lsp_cfg_pkg::lsp_cfg_t      cfg,
  input  lsp_sched_pkg::slot_vec_t   valid,
  input  lsp_sched_pkg::slot_vec_t   blast,
  input  logic [`LSP_NUM_CQ_QID-1:0] cmpblast,
  input  logic [`LSP_NUM_CQ_QID-1:0] atm_if_v,
  input  logic [`LSP_NUM_LB_CQ-1:0]  cq_ow,
  input  logic                       cq_pop,
  input  logic [`LSP_CQ_W-1:0]       pop_cq,
  output logic                       sched_v,
  output lsp_sched_pkg::sched_t      sched,
  output logic [`LSP_NUM_LB_CQ-1:0]  cq_has_work
);

  lsp_sched_pkg::slot_vec_t  v_blasted;
  logic [`LSP_NUM_LB_CQ-1:0] cq_arb_reqs;
  logic [`LSP_NUM_LB_CQ-1:0] cq_has_space;
  logic [`LSP_NUM_LB_CQ-1:0] cq_busy_sch;
  logic                      gnt_v;
  logic [`LSP_CQ_W-1:0]      gnt_cq;

  // qualification and per-CQ requests
  lsp_cq_sel u_cq_sel (
    .cfg          (cfg),
    .valid        (valid),
    .blast        (blast),
    .cmpblast     (cmpblast),
    .atm_if_v     (atm_if_v),
    .cq_has_space (cq_has_space),
    .cq_busy_sch  (cq_busy_sch),
    .cq_ow        (cq_ow),
    .v_blasted    (v_blasted),
    .any_has_work (cq_has_work),
    .cq_arb_reqs  (cq_arb_reqs)
  );

  lsp_cq_arb u_cq_arb (.clk(clk), .rst(rst), .reqs(cq_arb_reqs), .gnt_v(gnt_v), .gnt_cq(gnt_cq));

  // registers the schedule result, which sets the one cycle latency
  lsp_qidix_sel u_qidix_sel (
    .clk       (clk),
    .rst       (rst),
    .v_blasted (v_blasted),
    .gnt_v     (gnt_v),
    .gnt_cq    (gnt_cq),
    .sched_v   (sched_v),
    .sched     (sched)
  );

  // space and busy flags loop back into the selector
  lsp_cq_credit u_cq_credit (
    .clk          (clk),
    .rst          (rst),
    .sched_v      (sched_v),
    .sched        (sched),
    .cq_pop       (cq_pop),
    .pop_cq       (pop_cq),
    .cq_has_space (cq_has_space),
    .cq_busy_sch  (cq_busy_sch)
  );

endmodule

/* dv/lsp_sched_asserts.sv */
//--------------------------------------------------------------------
// bound into the scheduler top, the disable check uses the request-cycle cfg
//--------------------------------------------------------------------
`include "lsp_defines.svh"

module lsp_sched_asserts (
  input logic                  clk,
  input logic                  rst,
  input lsp_cfg_pkg::lsp_cfg_t cfg,
  input logic                  sched_v,
  input lsp_sched_pkg::sched_t sched
);
  timeunit 1ns;
  timeprecision 1ps;

  // the testbench reads this count when the run ends
  int fail_count = 0;
  // disables as they were when the scheduled CQ made its request
  logic [`LSP_NUM_LB_CQ-1:0] dis_q;

  always_ff @(posedge clk) begin
    dis_q <= cfg.cq_ldb_disable;
  end

  // the strobe register clears synchronously
  reset_clears_strobe: assert property (@(posedge clk) rst |=> !sched_v)
    else begin
      $error("sched_v high in the cycle after reset");
      fail_count++;
    end

  // busy_sch keeps a CQ out of the arbitration right after it won
  no_back_to_back: assert property (@(posedge clk) disable iff (rst)
    sched_v |=> !(sched_v && (sched.cq == $past(sched.cq))))
    else begin
      $error("same CQ scheduled in two consecutive cycles");
      fail_count++;
    end

  disabled_not_scheduled: assert property (@(posedge clk) disable iff (rst)
    sched_v |-> !dis_q[sched.cq])
    else begin
      $error("a disabled CQ was scheduled");
      fail_count++;
    end

endmodule

bind lsp_sched_top lsp_sched_asserts u_asserts (.*);

/* dv/lsp_sched_tb.sv */
//--------------------------------------------------------------------
// vectors come from dv/lsp_sched_stim.txt, 16 hex words each after a count word
//--------------------------------------------------------------------
`include "lsp_defines.svh"

module lsp_sched_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WORDS         = 16;
  localparam int MAX_VEC       = 64;
  localparam int RST_TIMEOUT   = 20;
  localparam int DRAIN_TIMEOUT = 20;
  localparam int FILL_CYCLES   = 40;

  logic                       clk;
  logic                       rst;
  lsp_cfg_pkg::lsp_cfg_t      cfg;
  lsp_sched_pkg::slot_vec_t   valid;
  lsp_sched_pkg::slot_vec_t   blast;
  logic [`LSP_NUM_CQ_QID-1:0] cmpblast;
  logic [`LSP_NUM_CQ_QID-1:0] atm_if_v;
  logic [`LSP_NUM_LB_CQ-1:0]  cq_ow;
  logic                       cq_pop;
  logic [`LSP_CQ_W-1:0]       pop_cq;
  logic                       sched_v;
  lsp_sched_pkg::sched_t      sched;
  logic [`LSP_NUM_LB_CQ-1:0]  cq_has_work;
  // word 0 is the vector count, vector v starts at word 1 + v*WORDS
  logic [31:0]                stim_mem [0:MAX_VEC*WORDS];
  logic [31:0]                lfsr_state;

  lsp_sched_top uut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //--------------------------------------------------------------------
  // helpers
  //--------------------------------------------------------------------

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_strobe(input logic exp, input logic act);
    if (exp !== act) stop_on_error($sformatf("[FAIL] t=%0t sched_v expected %0b got %0b",
                                             $time, exp, act));
  endtask

  task automatic check_sched(input lsp_sched_pkg::sched_t exp, input lsp_sched_pkg::sched_t act);
    if (exp !== act) stop_on_error($sformatf(
      "[FAIL] t=%0t sched expected cq=%0d qidix=%0d list=%0d got cq=%0d qidix=%0d list=%0d",
      $time, exp.cq, exp.qidix, exp.list, act.cq, act.qidix, act.list));
  endtask

  task automatic check_work(input logic [`LSP_NUM_LB_CQ-1:0] exp,
                            input logic [`LSP_NUM_LB_CQ-1:0] act);
    if (exp !== act) stop_on_error($sformatf("[FAIL] t=%0t cq_has_work expected %h got %h",
                                             $time, exp, act));
  endtask

  // taps 32, 22, 2, 1 and the new bit shifts in at the bottom
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [7:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[6:0], lfsr_state[0]};
    end
  endtask

  // words that were never loaded stay unknown
  function automatic logic has_unknown(input int base);
    for (int j = 0; j < WORDS; j++) begin
      if ($isunknown(stim_mem[base+j])) return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic apply_vector(input int base);
    cfg      = stim_mem[base][8:0];
    valid    = {stim_mem[base+1], stim_mem[base+2], stim_mem[base+3]};
    blast    = {stim_mem[base+4], stim_mem[base+5], stim_mem[base+6]};
    cmpblast = stim_mem[base+7];
    atm_if_v = stim_mem[base+8];
    cq_ow    = stim_mem[base+9][`LSP_NUM_LB_CQ-1:0];
    cq_pop   = stim_mem[base+10][3];
    pop_cq   = stim_mem[base+10][`LSP_CQ_W-1:0];
  endtask

  //--------------------------------------------------------------------
  // watchdog and main sequence
  //--------------------------------------------------------------------

  initial begin
    #20us;
    stop_on_error("simulation ran past its time limit");
  end

  initial begin
    int                    n_vec;
    int                    base;
    int                    waited;
    logic [7:0]            rbits;
    lsp_sched_pkg::sched_t exp_sched;
    rst = 1'b1;
    cfg = '0;
    valid = '0;
    blast = '0;
    cmpblast = '0;
    atm_if_v = '0;
    cq_ow = '0;
    cq_pop = 1'b0;
    pop_cq = '0;
    lfsr_state = 32'h0a60b3c0;
    $readmemh("dv/lsp_sched_stim.txt", stim_mem);
    if ($isunknown(stim_mem[0])) stop_on_error("could not read dv/lsp_sched_stim.txt");
    n_vec = int'(stim_mem[0]);
    if (n_vec > MAX_VEC) stop_on_error("stimulus file holds more vectors than the testbench");
    repeat (2) @(posedge clk);
    #1 rst = 1'b0;
    waited = 0;
    while (rst || sched_v !== 1'b0) begin
      @(posedge clk);
      waited++;
      if (waited > RST_TIMEOUT) stop_on_error("DUT did not come out of reset");
    end
    // drive a fixed delay after the edge and check just before the next one
    for (int v = 0; v < n_vec; v++) begin
      base = 1 + v * WORDS;
      if (has_unknown(base)) stop_on_error("stimulus file ended before all vectors were read");
      @(posedge clk);
      #1 apply_vector(base);
      #8;
      check_strobe(stim_mem[base+11][0], sched_v);
      if (stim_mem[base+11][0]) begin
        exp_sched.cq    = stim_mem[base+12][`LSP_CQ_W-1:0];
        exp_sched.qidix = stim_mem[base+13][`LSP_QIDIX_W-1:0];
        exp_sched.list  = lsp_sched_pkg::list_e'(stim_mem[base+14][1:0]);
        check_sched(exp_sched, sched);
      end
      check_work(stim_mem[base+15][`LSP_NUM_LB_CQ-1:0], cq_has_work);
    end
    waited = 0;
    while (sched_v !== 1'b0) begin
      @(posedge clk);
      #9 waited++;
      if (waited > DRAIN_TIMEOUT) stop_on_error("sched_v did not drain after the vectors");
    end
    // random pops with no work must never produce a schedule
    for (int c = 0; c < FILL_CYCLES; c++) begin
      @(posedge clk);
      #1 valid = '0;
      take_bits(1, rbits);
      cq_pop = rbits[0];
      take_bits(`LSP_CQ_W, rbits);
      pop_cq = rbits[`LSP_CQ_W-1:0];
      #8;
      check_strobe(1'b0, sched_v);
      check_work('0, cq_has_work);
    end
    @(posedge clk);
    #1 cq_pop = 1'b0;
    if (uut.u_asserts.fail_count == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("tests failed");
      $fatal(1, "concurrent assertions reported errors");
    end
  end

endmodule

/* flist.f */
+incdir+hdl
hdl/lsp_cfg_pkg.sv
hdl/lsp_sched_pkg.sv
hdl/lsp_cq_sel.sv
hdl/lsp_cq_arb.sv
hdl/lsp_qidix_sel.sv
hdl/lsp_cq_credit.sv
hdl/lsp_sched_top.sv
dv/lsp_sched_asserts.sv
dv/lsp_sched_tb.sv

/* dv/lsp_sched_stim.txt */
// cfg vs vr vn bs br bn cmpb atm ow pop(bit3 strobe, 2:0 cq) esv ecq eqx elst ehw
// first word is the vector count, expected sched is the strobe seen in that cycle
18
0   0        0        00001111 0        0 0 0        ffffffff 0  0 0 0 0 0 0f
0   0        0        00001111 0        0 0 0        ffffffff 0  0 1 0 0 2 0f
0   0        0        00001111 0        0 0 0        ffffffff 0  0 1 1 0 2 0f
0   0        0        00001111 0        0 0 0        ffffffff 0  0 1 2 0 2 0f
0   0        0        00001111 0        0 0 0        ffffffff 0  0 1 3 0 2 0f
0   0        0        0        0        0 0 0        ffffffff 0  0 1 0 0 2 00
0   00040000 00020000 00010000 0        0 0 0        ffffffff 0  0 0 0 0 0 10
0   0        0a000000 01000000 0        0 0 0        ffffffff 0  0 1 4 2 0 40
0   0        00050000 00080000 0        0 0 00010000 ffffffff 0  0 1 6 1 1 10
0   03000000 0        04000000 0        0 0 0        feffffff 0  0 1 4 2 1 40
100 00030000 0        00040000 00080000 0 0 0        ffffffff 0  0 1 6 1 0 10
0   03000000 0        04000000 01000000 0 0 0        ffffffff 0  0 1 4 2 2 40
0   0        0        0        0        0 0 0        ffffffff 0  0 1 6 1 0 00
0   0        0        00010000 0        0 0 0        ffffffff 0  0 0 0 0 0 10
0   0        0        00010000 0        0 0 0        ffffffff 0  0 1 4 0 2 10
0   0        0        00010000 0        0 0 0        ffffffff 0  0 0 0 0 0 10
0   0        0        00010000 0        0 0 0        ffffffff 0  c 0 0 0 0 10
0   0        0        00010000 0        0 0 0        ffffffff 0  0 0 0 0 0 10
0   0        0        00010000 0        0 0 0        ffffffff 0  c 1 4 0 2 10
0   0        0        00010000 0        0 0 0        ffffffff 0  0 0 0 0 0 10
0   0        0        00010000 0        0 0 0        ffffffff 0  0 1 4 0 2 10
080 0        0        20010100 0        0 0 0        ffffffff 04 0 0 0 0 0 94
080 0        0        20010100 0        0 0 0        ffffffff 04 0 0 0 0 0 94
0   0        0        0        0        0 0 0        ffffffff 0  0 0 0 0 0 00
